// ==== src/rvIsaPkg.sv ====
package rvIsaPkg;

    localparam int XLen     = 32;
    localparam int RegAddrW = 5;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10   // lui path
    } aluOpT;

    // Same values as funct3 of the B-type opcode
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondT;

    typedef enum logic [1:0] {
        jmpNone = 2'd0,
        jmpJal  = 2'd1,
        jmpJalr = 2'd2
    } jumpKindT;

    typedef enum logic [1:0] {
        pcSrcSeq = 2'd0,   // pc + 4
        pcSrcRel = 2'd1,   // pc + imm
        pcSrcAlu = 2'd2    // ALU result with bit 0 cleared
    } pcSrcT;

endpackage

// ==== src/execPipePkg.sv ====
package execPipePkg;

    import rvIsaPkg::*;

    localparam int NumLanes = 2;

    typedef enum logic [2:0] {
        fwdRegFile = 3'b000,
        fwdOwnW    = 3'b001,
        fwdOwnM    = 3'b010,
        fwdOtherM  = 3'b011,
        fwdOtherW  = 3'b100
    } fwdSelT;

    typedef struct packed {
        jumpKindT   jump;
        logic       branch;
        branchCondT branchCond;
        aluOpT      aluOp;
        logic       srcAIsPc;
        logic       srcBIsImm;
    } execCtrlT;

    typedef struct packed {
        logic                valid;
        execCtrlT            ctrl;
        logic [RegAddrW-1:0] rs1;
        logic [RegAddrW-1:0] rs2;
        logic [RegAddrW-1:0] rd;
        logic [XLen-1:0]     pc;
        logic [XLen-1:0]     imm;
    } issueSlotT;

    typedef struct packed {
        logic                valid;
        execCtrlT            ctrl;
        logic [RegAddrW-1:0] rd;
        logic [XLen-1:0]     pc;
        logic [XLen-1:0]     imm;
        logic [XLen-1:0]     rs1Val;
        logic [XLen-1:0]     rs2Val;
        fwdSelT              fwdA;
        fwdSelT              fwdB;
    } execSlotT;

    typedef struct packed {
        logic                valid;
        logic                lane;       // Trace only
        logic [RegAddrW-1:0] rd;
        logic [XLen-1:0]     value;
        pcSrcT               pcSrc;
        logic [XLen-1:0]     target;
        logic [XLen-1:0]     storeData;
    } laneResultT;

    typedef struct packed {
        logic [XLen-1:0] mVal;
        logic [XLen-1:0] wVal;
    } bypassT;

    typedef struct packed {
        logic                en;
        logic [RegAddrW-1:0] rd;
        logic [XLen-1:0]     value;
    } wbPortT;

    typedef struct packed {
        logic                valid;
        logic [RegAddrW-1:0] rd;
    } destT;

endpackage

// ==== src/alu.sv ====
module alu (
    input  logic [rvIsaPkg::XLen-1:0] srcA,
    input  logic [rvIsaPkg::XLen-1:0] srcB,
    input  rvIsaPkg::aluOpT           aluOp,
    output logic [rvIsaPkg::XLen-1:0] result,
    output logic                      zero
);
    import rvIsaPkg::*;

    logic [4:0] shamt;

    assign shamt = srcB[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:   result = srcA + srcB;
            aluSub:   result = srcA - srcB;
            aluAnd:   result = srcA & srcB;
            aluOr:    result = srcA | srcB;
            aluXor:   result = srcA ^ srcB;
            aluSll:   result = srcA << shamt;
            aluSrl:   result = srcA >> shamt;
            aluSra:   result = $signed(srcA) >>> shamt;
            aluSlt:   result = {{(XLen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu:  result = {{(XLen-1){1'b0}}, srcA < srcB};
            aluPassB: result = srcB;
            default:  result = '0;
        endcase
    end

    // Branches compare through sub or slt, then test this flag
    assign zero = (result == '0);

endmodule

// ==== src/branchUnit.sv ====
module branchUnit (
    input  rvIsaPkg::jumpKindT   jump,
    input  logic                 branch,
    input  rvIsaPkg::branchCondT branchCond,
    input  logic                 zero,
    output rvIsaPkg::pcSrcT      pcSrc
);
    import rvIsaPkg::*;

    logic taken;

    always_comb begin
        case (branchCond)
            brEq:    taken = zero;    // sub
            brNe:    taken = !zero;
            brLt:    taken = !zero;   // slt gave 1
            brGe:    taken = zero;
            brLtu:   taken = !zero;   // sltu gave 1
            brGeu:   taken = zero;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jump == jmpJal) begin
            pcSrc = pcSrcRel;
        end else if (jump == jmpJalr) begin
            pcSrc = pcSrcAlu;
        end else if (branch && taken) begin
            pcSrc = pcSrcRel;
        end else begin
            pcSrc = pcSrcSeq;
        end
    end

endmodule

// ==== src/executeLane.sv ====
module executeLane (
    input  logic                    lane,
    input  execPipePkg::execSlotT   slot,
    input  execPipePkg::bypassT     ownBypass,
    input  execPipePkg::bypassT     otherBypass,
    output execPipePkg::laneResultT result
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    logic [XLen-1:0] opA;
    logic [XLen-1:0] opB;
    logic [XLen-1:0] srcA;
    logic [XLen-1:0] srcB;
    logic [XLen-1:0] aluResult;
    logic            zero;
    pcSrcT           pcSrc;

    function automatic logic [XLen-1:0] forwardOp(
        input fwdSelT          sel,
        input logic [XLen-1:0] regVal
    );
        case (sel)
            fwdOwnW:   return ownBypass.wVal;
            fwdOwnM:   return ownBypass.mVal;
            fwdOtherM: return otherBypass.mVal;
            fwdOtherW: return otherBypass.wVal;
            default:   return regVal;
        endcase
    endfunction

    always_comb begin
        opA  = forwardOp(slot.fwdA, slot.rs1Val);
        opB  = forwardOp(slot.fwdB, slot.rs2Val);
        srcA = slot.ctrl.srcAIsPc ? slot.pc : opA;    // auipc, jal
        srcB = slot.ctrl.srcBIsImm ? slot.imm : opB;
    end

    alu aluInst (
        .srcA   (srcA),
        .srcB   (srcB),
        .aluOp  (slot.ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    branchUnit branchInst (
        .jump       (slot.ctrl.jump),
        .branch     (slot.ctrl.branch),
        .branchCond (slot.ctrl.branchCond),
        .zero       (zero),
        .pcSrc      (pcSrc)
    );

    always_comb begin
        result.valid     = slot.valid;
        result.lane      = lane;
        result.rd        = slot.rd;
        result.value     = (slot.ctrl.jump != jmpNone) ? slot.pc + XLen'(4) : aluResult;
        result.pcSrc     = pcSrc;
        result.target    = (pcSrc == pcSrcAlu) ? {aluResult[XLen-1:1], 1'b0}
                                               : slot.pc + slot.imm;
        result.storeData = opB;   // Forwarded rs2
    end

endmodule

// ==== src/issueStage.sv ====
module issueStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  execPipePkg::issueSlotT issuePair [execPipePkg::NumLanes],
    input  logic                   redirect,
    input  execPipePkg::wbPortT    wbPort [execPipePkg::NumLanes],
    input  execPipePkg::destT      mDest [execPipePkg::NumLanes],
    output execPipePkg::execSlotT  execSlot [execPipePkg::NumLanes]
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    logic [XLen-1:0] regFile [2**RegAddrW];
    execSlotT        execNext [NumLanes];

    function automatic logic [XLen-1:0] readReg(input logic [RegAddrW-1:0] addr);
        logic [XLen-1:0] val;
        val = regFile[addr];
        for (int w = 0; w < NumLanes; w++) begin
            if (wbPort[w].en && wbPort[w].rd == addr) begin
                val = wbPort[w].value;   // Write-through with lane 1 last
            end
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    // Producers in execute now sit in memory when the consumer executes;
    // those in memory now sit in writeback. Later matches take priority.
    function automatic fwdSelT pickFwd(input logic [RegAddrW-1:0] src, input int lane);
        fwdSelT sel;
        sel = fwdRegFile;
        if (src != '0) begin
            for (int p = 0; p < NumLanes; p++) begin
                if (mDest[p].valid && mDest[p].rd == src) begin
                    sel = (p == lane) ? fwdOwnW : fwdOtherW;
                end
            end
            for (int p = 0; p < NumLanes; p++) begin
                if (execSlot[p].valid && execSlot[p].rd == src) begin
                    sel = (p == lane) ? fwdOwnM : fwdOtherM;
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        for (int l = 0; l < NumLanes; l++) begin
            execNext[l].valid  = issuePair[l].valid && !redirect;   // Wrong path
            execNext[l].ctrl   = issuePair[l].ctrl;
            execNext[l].rd     = issuePair[l].rd;
            execNext[l].pc     = issuePair[l].pc;
            execNext[l].imm    = issuePair[l].imm;
            execNext[l].rs1Val = readReg(issuePair[l].rs1);
            execNext[l].rs2Val = readReg(issuePair[l].rs2);
            execNext[l].fwdA   = pickFwd(issuePair[l].rs1, l);
            execNext[l].fwdB   = pickFwd(issuePair[l].rs2, l);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NumLanes; w++) begin
            if (wbPort[w].en && wbPort[w].rd != '0) begin
                regFile[wbPort[w].rd] <= wbPort[w].value;   // Lane 1 wins on same rd
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int l = 0; l < NumLanes; l++) begin
                execSlot[l] <= '0;
            end
        end else begin
            for (int l = 0; l < NumLanes; l++) begin
                execSlot[l] <= execNext[l];
            end
        end
    end

endmodule

// ==== src/retireStage.sv ====
module retireStage (
    input  logic                              clk,
    input  logic                              rstN,
    input  execPipePkg::laneResultT           laneResult [execPipePkg::NumLanes],
    output execPipePkg::bypassT               bypass [execPipePkg::NumLanes],
    output logic                              redirect,
    output logic [rvIsaPkg::XLen-1:0]         redirectPc,
    output execPipePkg::wbPortT               wbPort [execPipePkg::NumLanes],
    output logic [rvIsaPkg::XLen-1:0]         storeData [execPipePkg::NumLanes],
    output execPipePkg::destT                 mDest [execPipePkg::NumLanes]
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    laneResultT memNext [NumLanes];
    laneResultT memQ [NumLanes];
    laneResultT wbQ [NumLanes];
    logic       olderTaken;

    // Squash on entry to memory
    always_comb begin
        olderTaken = 1'b0;
        for (int l = 0; l < NumLanes; l++) begin
            memNext[l]       = laneResult[l];
            memNext[l].valid = laneResult[l].valid && !redirect && !olderTaken;
            olderTaken       = olderTaken || (memNext[l].valid && laneResult[l].pcSrc != pcSrcSeq);
        end
    end

    // Oldest taken lane in memory owns the redirect
    always_comb begin
        redirect   = 1'b0;
        redirectPc = memQ[0].target;
        for (int l = 0; l < NumLanes; l++) begin
            if (!redirect && memQ[l].valid && memQ[l].pcSrc != pcSrcSeq) begin
                redirect   = 1'b1;
                redirectPc = memQ[l].target;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int l = 0; l < NumLanes; l++) begin
                memQ[l] <= '0;
                wbQ[l]  <= '0;
            end
        end else begin
            for (int l = 0; l < NumLanes; l++) begin
                memQ[l] <= memNext[l];
                wbQ[l]  <= memQ[l];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < NumLanes; l++) begin
            bypass[l].mVal  = memQ[l].value;
            bypass[l].wVal  = wbQ[l].value;
            wbPort[l].en    = wbQ[l].valid;
            wbPort[l].rd    = wbQ[l].rd;
            wbPort[l].value = wbQ[l].value;
            storeData[l]    = memQ[l].storeData;
            mDest[l].valid  = memQ[l].valid;
            mDest[l].rd     = memQ[l].rd;
        end
    end

endmodule

// ==== src/dualExecute.sv ====
module dualExecute (
    input  logic                      clk,
    input  logic                      rstN,
    input  execPipePkg::issueSlotT    issuePair [execPipePkg::NumLanes],
    output logic                      redirect,
    output logic [rvIsaPkg::XLen-1:0] redirectPc,
    output execPipePkg::wbPortT       wbPort [execPipePkg::NumLanes],
    output logic [rvIsaPkg::XLen-1:0] storeData [execPipePkg::NumLanes]
);
    import execPipePkg::*;

    execSlotT   execSlot [NumLanes];
    laneResultT laneResult [NumLanes];
    bypassT     bypass [NumLanes];
    destT       mDest [NumLanes];

    issueStage issueInst (
        .clk       (clk),
        .rstN      (rstN),
        .issuePair (issuePair),
        .redirect  (redirect),
        .wbPort    (wbPort),
        .mDest     (mDest),
        .execSlot  (execSlot)
    );

    for (genvar i = 0; i < NumLanes; i++) begin : genLane
        executeLane laneInst (
            .lane        (1'(i)),
            .slot        (execSlot[i]),
            .ownBypass   (bypass[i]),
            .otherBypass (bypass[NumLanes-1-i]),
            .result      (laneResult[i])
        );
    end

    retireStage retireInst (
        .clk        (clk),
        .rstN       (rstN),
        .laneResult (laneResult),
        .bypass     (bypass),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbPort     (wbPort),
        .storeData  (storeData),
        .mDest      (mDest)
    );

endmodule

// ==== test/dualExecuteTb.sv ====
module dualExecuteTb;
    import rvIsaPkg::*;
    import execPipePkg::*;

    localparam int NumRandPairs = 2000;
    localparam int TestCycles   = 16 + 4 + 4 + 2 + NumRandPairs + 6;
    localparam int CycleLimit   = TestCycles + 50;
    localparam int ExpDepth     = CycleLimit + 8;

    logic            clk;
    logic            rstN;
    issueSlotT       issuePair [NumLanes];
    logic            redirect;
    logic [XLen-1:0] redirectPc;
    wbPortT          wbPort [NumLanes];
    logic [XLen-1:0] storeData [NumLanes];

    logic [XLen-1:0] archReg [2**RegAddrW];
    wbPortT          expWb [ExpDepth][NumLanes];
    logic            expStoreEn [ExpDepth][NumLanes];
    logic [XLen-1:0] expStore [ExpDepth][NumLanes];
    logic            expRedirect [ExpDepth];
    logic [XLen-1:0] expRedirectPc [ExpDepth];
    logic [31:0]     lcgState;
    int              cycleCount;
    int              skipPairs;
    int              wbErrors;
    int              redirectErrors;
    int              storeErrors;
    string           testName;

    dualExecute UUT (
        .clk        (clk),
        .rstN       (rstN),
        .issuePair  (issuePair),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbPort     (wbPort),
        .storeData  (storeData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            reportCounts();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randBelow(input int n);
        return int'((nextRand() >> 8) % 32'(n));
    endfunction

    // RV32I semantics of each operation
    function automatic logic [XLen-1:0] aluModel(input aluOpT op, input logic [XLen-1:0] a,
                                                 input logic [XLen-1:0] b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSll:  return a << b[4:0];
            aluSrl:  return a >> b[4:0];
            aluSra:  return $signed(a) >>> b[4:0];
            aluSlt:  return XLen'($signed(a) < $signed(b));
            aluSltu: return XLen'(a < b);
            default: return b;   // lui
        endcase
    endfunction

    function automatic logic branchTaken(input branchCondT cond, input logic [XLen-1:0] a,
                                         input logic [XLen-1:0] b);
        case (cond)
            brEq:    return a == b;
            brNe:    return a != b;
            brLt:    return $signed(a) < $signed(b);
            brGe:    return $signed(a) >= $signed(b);
            brLtu:   return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic issueSlotT aluSlot(input int rd, input int rs1, input int rs2,
                                          input aluOpT op);
        issueSlotT s;
        s            = '0;
        s.valid      = 1'b1;
        s.ctrl.aluOp = op;
        s.rd         = RegAddrW'(rd);
        s.rs1        = RegAddrW'(rs1);
        s.rs2        = RegAddrW'(rs2);
        return s;
    endfunction

    function automatic issueSlotT randomSlot(input logic [XLen-1:0] pc);
        issueSlotT s;
        int        kind;
        int        cond;
        s            = '0;
        s.valid      = 1'b1;
        s.rd         = RegAddrW'(randBelow(8));   // x0..x7 keeps hazards frequent
        s.rs1        = RegAddrW'(randBelow(8));
        s.rs2        = RegAddrW'(randBelow(8));
        s.pc         = pc;
        s.imm        = XLen'(randBelow(128) - 64);
        s.ctrl.aluOp = aluOpT'(4'(randBelow(11)));
        kind         = randBelow(16);
        if (kind < 12) begin
            s.ctrl.srcAIsPc  = (kind == 0);   // auipc
            s.ctrl.srcBIsImm = kind[0];
        end else if (kind < 14) begin
            cond              = randBelow(6);
            s.rd              = '0;
            s.imm             = XLen'(4 * (randBelow(32) - 16));
            s.ctrl.branch     = 1'b1;
            s.ctrl.branchCond = branchCondT'(3'(cond < 2 ? cond : cond + 2));
            s.ctrl.aluOp      = (cond < 2) ? aluSub : (cond < 4) ? aluSlt : aluSltu;
        end else if (kind == 14) begin
            s.imm            = XLen'(4 * (randBelow(32) - 16));
            s.ctrl.aluOp     = aluAdd;
            s.ctrl.srcBIsImm = 1'b1;
            s.ctrl.jump      = (randBelow(2) == 0) ? jmpJal : jmpJalr;
            s.ctrl.srcAIsPc  = (s.ctrl.jump == jmpJal);
        end else begin
            s.valid = 1'b0;
        end
        return s;
    endfunction

    task automatic modelLane(input issueSlotT s, output logic [XLen-1:0] value,
                             output logic taken, output logic [XLen-1:0] target);
        logic [XLen-1:0] a;
        logic [XLen-1:0] b;
        a      = archReg[s.rs1];
        b      = archReg[s.rs2];
        value  = aluModel(s.ctrl.aluOp, s.ctrl.srcAIsPc ? s.pc : a, s.ctrl.srcBIsImm ? s.imm : b);
        taken  = (s.ctrl.jump != jmpNone) ||
                 (s.ctrl.branch && branchTaken(s.ctrl.branchCond, a, b));
        target = (s.ctrl.jump == jmpJalr) ? ((a + s.imm) & ~32'd1) : s.pc + s.imm;
        if (s.ctrl.jump != jmpNone) begin
            value = s.pc + 32'd4;   // Link value
        end
    endtask

    // Drives one pair and books store and redirect 3 counts ahead and writeback 4 ahead
    task automatic presentPair(input issueSlotT s0, input issueSlotT s1);
        issueSlotT       slot [NumLanes];
        logic [XLen-1:0] value [NumLanes];
        logic [XLen-1:0] target [NumLanes];
        logic            taken [NumLanes];
        logic            live [NumLanes];
        int              c;
        c            = cycleCount;
        slot[0]      = s0;
        slot[1]      = s1;
        issuePair[0] <= s0;
        issuePair[1] <= s1;
        if (skipPairs > 0) begin
            skipPairs--;   // Wrong path
        end else begin
            for (int l = 0; l < NumLanes; l++) begin
                modelLane(slot[l], value[l], taken[l], target[l]);
                live[l] = slot[l].valid && !(l > 0 && live[0] && taken[0]);
                if (live[l]) begin
                    expWb[c+4][l]      = '{en: 1'b1, rd: slot[l].rd, value: value[l]};
                    expStoreEn[c+3][l] = 1'b1;
                    expStore[c+3][l]   = archReg[slot[l].rs2];
                end
            end
            for (int l = 0; l < NumLanes; l++) begin
                if (live[l] && slot[l].rd != '0) begin
                    archReg[slot[l].rd] = value[l];
                end
            end
            for (int l = NumLanes - 1; l >= 0; l--) begin
                if (live[l] && taken[l]) begin
                    expRedirect[c+3]   = 1'b1;   // Older lane overrides
                    expRedirectPc[c+3] = target[l];
                    skipPairs          = 2;
                end
            end
        end
    endtask

    task automatic checkWb(input string name, input int lane, input wbPortT exp,
                           input wbPortT act);
        if (act.en !== exp.en || (exp.en && (act.rd !== exp.rd || act.value !== exp.value))) begin
            $display("Mismatch %s wbPort[%0d] at cycle %0d: expected %h actual %h",
                     name, lane, cycleCount, exp, act);
            wbErrors++;
        end
    endtask

    task automatic checkRedirect(input string name, input logic expValid,
                                 input logic [XLen-1:0] expPc, input logic actValid,
                                 input logic [XLen-1:0] actPc);
        if (actValid !== expValid || (expValid && actPc !== expPc)) begin
            $display("Mismatch %s redirect at cycle %0d: expected %b/%h actual %b/%h",
                     name, cycleCount, expValid, expPc, actValid, actPc);
            redirectErrors++;
        end
    endtask

    task automatic checkStore(input string name, input int lane, input logic [XLen-1:0] exp,
                              input logic [XLen-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s storeData[%0d] at cycle %0d: expected %h actual %h",
                     name, lane, cycleCount, exp, act);
            storeErrors++;
        end
    endtask

    task automatic reportCounts();
        $display("Errors: writeback %0d, redirect %0d, store data %0d",
                 wbErrors, redirectErrors, storeErrors);
    endtask

    always @(negedge clk) begin
        if (cycleCount > 0) begin
            for (int l = 0; l < NumLanes; l++) begin
                checkWb(testName, l, expWb[cycleCount][l], wbPort[l]);
                if (expStoreEn[cycleCount][l]) begin
                    checkStore(testName, l, expStore[cycleCount][l], storeData[l]);
                end
            end
            checkRedirect(testName, expRedirect[cycleCount], expRedirectPc[cycleCount],
                          redirect, redirectPc);
        end
    end

    initial begin
        issueSlotT       s0;
        issueSlotT       s1;
        logic [XLen-1:0] pc;
        lcgState  = 32'h23b5_2d1f;
        skipPairs = 0;
        testName  = "reset";
        for (int i = 0; i < ExpDepth; i++) begin
            expRedirect[i]   = 1'b0;
            expRedirectPc[i] = '0;
            for (int l = 0; l < NumLanes; l++) begin
                expWb[i][l]      = '0;
                expStoreEn[i][l] = 1'b0;
                expStore[i][l]   = '0;
            end
        end
        for (int r = 0; r < 2**RegAddrW; r++) begin
            archReg[r] = '0;
        end
        rstN         <= 1'b0;
        issuePair[0] <= '0;
        issuePair[1] <= '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) @(posedge clk);   // Idle with quiet outputs
        testName = "clear";
        for (int r = 1; r < 8; r += 2) begin
            @(posedge clk);
            presentPair(aluSlot(r, 0, 0, aluAdd), aluSlot(r + 1, 0, 0, aluAdd));
        end
        testName = "readZero";
        for (int r = 1; r < 8; r += 4) begin
            @(posedge clk);
            presentPair(aluSlot(0, r, r + 1, aluOr), aluSlot(0, r + 2, r + 3, aluOr));
        end
        testName = "random";
        for (int i = 0; i < NumRandPairs; i++) begin
            @(posedge clk);
            pc = nextRand() & 32'h0000_fff8;
            s0 = randomSlot(pc);
            s1 = randomSlot(pc + 32'd4);
            while (s0.valid && s0.rd != '0 && (s1.rs1 == s0.rd || s1.rs2 == s0.rd)) begin
                s1 = randomSlot(pc + 32'd4);   // Lane 1 never reads lane 0's destination
            end
            presentPair(s0, s1);
        end
        testName = "drain";
        repeat (6) begin
            @(posedge clk);
            presentPair('0, '0);
        end
        reportCounts();
        if (wbErrors + redirectErrors + storeErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/rvIsaPkg.sv
src/execPipePkg.sv
src/alu.sv
src/branchUnit.sv
src/executeLane.sv
src/issueStage.sv
src/retireStage.sv
src/dualExecute.sv
test/dualExecuteTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module dualExecuteTb -f verilog.f -o simv

output=$(./obj_dir/simv)
echo "$output"

if grep -q "^TESTBENCH PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi
